// ==== hdl/tempSens_consts.svh ====
`ifndef TEMPSENS_CONSTS_SVH
`define TEMPSENS_CONSTS_SVH

// Analog front end charge time after reset
`define PRECHARGE_CYCLES 16

// Switch step lengths in clk cycles
`define DIODE_CYCLES 8
`define BIGDIODE_MAX 8
`define CHARGE_CYCLES 6

// Chop cycles per phase
`define BANDGAP_CHOPS 4
`define PTAT_CHOPS 4

// Conversion window and power-down time
`define TEMPSENS_CYCLES 200
`define SLEEP_CYCLES 32

// Result width, count saturates at all ones
`define COUNT_WIDTH 8

`endif

// ==== hdl/tempSensPkg.sv ====
`default_nettype none

package tempSensPkg;

    // Measurement phases, in loop order
    typedef enum logic [2:0] {
        PRECHARGE,
        BANDGAP,
        PTAT,
        TEMPSENS,
        SLEEP
    } phase_t;

    // Switch steps within a chop cycle
    typedef enum logic [2:0] {
        BLANK,
        DIODE,
        BIGDIODE,
        HCHARGE,
        LCHARGE,
        OUTPUT
    } step_t;

endpackage

`default_nettype wire

// ==== hdl/phaseSequencer.sv ====
`default_nettype none

`include "tempSens_consts.svh"

module phaseSequencer
    import tempSensPkg::*;
(
    input  wire    clk,
    input  wire    reset,
    input  wire    chopDone,
    output phase_t phase,
    output logic   pwrUp,
    output logic   preChrg,
    output logic   sBgCtrl,
    output logic   sPtatCtrl,
    output logic   sBg2Cmp,
    output logic   sRdisconN,
    output logic   sCap2Cmp,
    output logic   sRef2Cmp,
    output logic   sCapRst,
    output logic   sPtatOut
);

    // Cycle count in timed phases, chop count in chopped phases
    logic [7:0] cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= PRECHARGE;
            cnt   <= '0;
        end else begin
            case (phase)
                PRECHARGE: begin
                    // Outputs trail phase by one cycle, so end a count early
                    if (cnt == 8'(`PRECHARGE_CYCLES - 2)) begin
                        phase <= BANDGAP;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                BANDGAP: begin
                    if (chopDone) begin
                        if (cnt == 8'(`BANDGAP_CHOPS - 1)) begin
                            phase <= PTAT;
                            cnt   <= '0;
                        end else begin
                            cnt <= cnt + 8'd1;
                        end
                    end
                end
                PTAT: begin
                    if (chopDone) begin
                        if (cnt == 8'(`PTAT_CHOPS - 1)) begin
                            phase <= TEMPSENS;
                            cnt   <= '0;
                        end else begin
                            cnt <= cnt + 8'd1;
                        end
                    end
                end
                TEMPSENS: begin
                    if (cnt == 8'(`TEMPSENS_CYCLES - 1)) begin
                        phase <= SLEEP;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                SLEEP: begin
                    if (cnt == 8'(`SLEEP_CYCLES - 1)) begin
                        phase <= BANDGAP;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 8'd1;
                    end
                end
                default: begin
                    phase <= PRECHARGE;
                    cnt   <= '0;
                end
            endcase
        end
    end

    // Bias and routing levels per phase
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwrUp     <= 1'b1;
            preChrg   <= 1'b1;
            sBgCtrl   <= 1'b1;
            sPtatCtrl <= 1'b0;
            sBg2Cmp   <= 1'b0;
            sRdisconN <= 1'b1;
            sCap2Cmp  <= 1'b0;
            sRef2Cmp  <= 1'b0;
            sCapRst   <= 1'b1;
            sPtatOut  <= 1'b0;
        end else begin
            pwrUp     <= 1'b1;
            preChrg   <= 1'b0;
            sBgCtrl   <= 1'b0;
            sPtatCtrl <= 1'b0;
            sBg2Cmp   <= 1'b0;
            sRdisconN <= 1'b0;
            sCap2Cmp  <= 1'b0;
            sRef2Cmp  <= 1'b0;
            sCapRst   <= 1'b1;
            sPtatOut  <= 1'b0;
            case (phase)
                PRECHARGE: begin
                    preChrg   <= 1'b1;
                    sBgCtrl   <= 1'b1;
                    sRdisconN <= 1'b1;
                end
                BANDGAP: begin
                    sBgCtrl   <= 1'b1;
                    sRdisconN <= 1'b1;
                    sBg2Cmp   <= 1'b1;
                end
                PTAT: begin
                    sPtatCtrl <= 1'b1;
                    sBg2Cmp   <= 1'b1;
                end
                TEMPSENS: begin
                    sPtatCtrl <= 1'b1;
                    sCap2Cmp  <= 1'b1;
                    sRef2Cmp  <= 1'b1;
                    sCapRst   <= 1'b0;
                    sPtatOut  <= 1'b1;
                end
                SLEEP: begin
                    pwrUp     <= 1'b0;
                    sRdisconN <= 1'b1;
                end
                default: begin
                    preChrg <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/switchSequencer.sv ====
`default_nettype none

`include "tempSens_consts.svh"

module switchSequencer
    import tempSensPkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wire         cmp,
    input  wire phase_t phase,
    output logic        chopDone,
    output logic        cmpRise,
    output logic        pi1,
    output logic        pi2,
    output logic        pii1,
    output logic        pii2,
    output logic        pa,
    output logic        pb,
    output logic        pc,
    output logic        pd,
    output logic        srcN,
    output logic        snk,
    output logic        cmpP1,
    output logic        cmpP2
);

    step_t      step;
    step_t      pendStep;
    step_t      upcoming;
    logic [2:0] seqIdx;
    logic [2:0] lastIdx;
    logic [3:0] stepCnt;
    logic       stepDone;
    logic       cmpMeta;
    logic       cmpS;
    logic       cmpDly;
    logic       cmpRef;

    // Chop cycle contents per phase
    function automatic step_t seqStep(input phase_t ph, input logic [2:0] idx);
        step_t s;
        s = BLANK;
        if (ph == BANDGAP) begin
            case (idx)
                3'd0: s = HCHARGE;
                3'd1: s = BIGDIODE;
                3'd2: s = DIODE;
                3'd3: s = LCHARGE;
                3'd4: s = BIGDIODE;
                3'd5: s = DIODE;
                3'd6: s = OUTPUT;
                default: s = BLANK;
            endcase
        end else if (ph == PTAT) begin
            s = (idx == 3'd0) ? BIGDIODE : DIODE;
        end
        return s;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmpMeta <= 1'b0;
            cmpS    <= 1'b0;
            cmpDly  <= 1'b0;
        end else begin
            cmpMeta <= cmp;
            cmpS    <= cmpMeta;
            cmpDly  <= cmpS;
        end
    end

    assign cmpRise = cmpS & ~cmpDly;

    // A new chop picks its first step from the phase it starts in
    assign upcoming = (seqIdx == 3'd0) ? seqStep(phase, 3'd0) : pendStep;
    assign lastIdx  = (phase == BANDGAP) ? 3'd6 : 3'd1;

    always_comb begin
        case (step)
            DIODE:    stepDone = (stepCnt == 4'(`DIODE_CYCLES - 1));
            HCHARGE,
            LCHARGE:  stepDone = (stepCnt == 4'(`CHARGE_CYCLES - 1));
            BIGDIODE: stepDone = (stepCnt >= 4'd1 && cmpS != cmpRef) ||
                                 (stepCnt == 4'(`BIGDIODE_MAX - 1));
            OUTPUT:   stepDone = 1'b1;
            default:  stepDone = 1'b0;
        endcase
    end

    assign chopDone = stepDone && (seqIdx == lastIdx);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step     <= BLANK;
            pendStep <= BLANK;
            seqIdx   <= '0;
            stepCnt  <= '0;
            cmpRef   <= 1'b0;
        end else if (phase != BANDGAP && phase != PTAT) begin
            step    <= BLANK;
            seqIdx  <= '0;
            stepCnt <= '0;
        end else if (step == BLANK) begin
            step    <= upcoming;
            stepCnt <= '0;
            if (upcoming == BIGDIODE) begin
                cmpRef <= cmpS;
            end
        end else if (stepDone) begin
            step    <= BLANK;
            stepCnt <= '0;
            if (seqIdx == lastIdx) begin
                seqIdx <= '0;
            end else begin
                seqIdx   <= seqIdx + 3'd1;
                pendStep <= seqStep(phase, seqIdx + 3'd1);
            end
        end else begin
            stepCnt <= stepCnt + 4'd1;
        end
    end

    // Chopping flips per diode step, per comparator edge in the window
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmpP1 <= 1'b1;
        end else if (phase == TEMPSENS) begin
            if (cmpRise) begin
                cmpP1 <= ~cmpP1;
            end
        end else if (step == DIODE && stepDone) begin
            cmpP1 <= ~cmpP1;
        end
    end

    assign cmpP2 = ~cmpP1;

    // Diode pre-select during the blank ahead of each diode step
    assign pi1  = (step == BLANK) && (upcoming == BIGDIODE);
    assign pii1 = (step == BLANK) && (upcoming == DIODE);
    assign pi2  = (step == BIGDIODE);
    assign pii2 = (step == DIODE);

    assign pa = (step == HCHARGE) || (step == LCHARGE);
    assign pb = (step == HCHARGE) || (step == OUTPUT);
    assign pc = (step == LCHARGE) || (step == OUTPUT);
    assign pd = (step == OUTPUT);

    // Current steering while comparator still agrees with its start value
    assign srcN = (step == BIGDIODE) && (cmpS == cmpRef) && cmpS;
    assign snk  = (step == BIGDIODE) && (cmpS == cmpRef) && !cmpS;

endmodule

`default_nettype wire

// ==== hdl/conversionCounter.sv ====
`default_nettype none

`include "tempSens_consts.svh"

module conversionCounter
    import tempSensPkg::*;
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire phase_t              phase,
    input  wire                      cmpRise,
    output logic [`COUNT_WIDTH-1:0]  tmpCount,
    output logic                     valid
);

    localparam logic [`COUNT_WIDTH-1:0] COUNT_MAX = {`COUNT_WIDTH{1'b1}};

    logic [`COUNT_WIDTH-1:0] count;
    logic                    wasTemp;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count    <= '0;
            wasTemp  <= 1'b0;
            tmpCount <= '0;
            valid    <= 1'b0;
        end else begin
            wasTemp <= (phase == TEMPSENS);
            valid   <= 1'b0;
            if (phase == TEMPSENS) begin
                if (!wasTemp) begin
                    // First window cycle restarts the count
                    count <= cmpRise ? `COUNT_WIDTH'(1) : '0;
                end else if (cmpRise && count != COUNT_MAX) begin
                    count <= count + `COUNT_WIDTH'(1);
                end
            end else if (wasTemp) begin
                tmpCount <= count;
                valid    <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tempSensCtrl.sv ====
`default_nettype none

`include "tempSens_consts.svh"

module tempSensCtrl
    import tempSensPkg::*;
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      cmp,
    output logic                     pwrUp,
    output logic                     preChrg,
    output logic                     sBgCtrl,
    output logic                     sPtatCtrl,
    output logic                     sBg2Cmp,
    output logic                     sRdisconN,
    output logic                     sCap2Cmp,
    output logic                     sRef2Cmp,
    output logic                     sCapRst,
    output logic                     sPtatOut,
    output logic                     pi1,
    output logic                     pi2,
    output logic                     pii1,
    output logic                     pii2,
    output logic                     pa,
    output logic                     pb,
    output logic                     pc,
    output logic                     pd,
    output logic                     srcN,
    output logic                     snk,
    output logic                     cmpP1,
    output logic                     cmpP2,
    output logic [`COUNT_WIDTH-1:0]  tmpCount,
    output logic                     valid
);

    phase_t phase;
    logic   chopDone;
    logic   cmpRise;

    phaseSequencer phaseSequencer_inst (
        .clk       (clk),
        .reset     (reset),
        .chopDone  (chopDone),
        .phase     (phase),
        .pwrUp     (pwrUp),
        .preChrg   (preChrg),
        .sBgCtrl   (sBgCtrl),
        .sPtatCtrl (sPtatCtrl),
        .sBg2Cmp   (sBg2Cmp),
        .sRdisconN (sRdisconN),
        .sCap2Cmp  (sCap2Cmp),
        .sRef2Cmp  (sRef2Cmp),
        .sCapRst   (sCapRst),
        .sPtatOut  (sPtatOut)
    );

    switchSequencer switchSequencer_inst (
        .clk      (clk),
        .reset    (reset),
        .cmp      (cmp),
        .phase    (phase),
        .chopDone (chopDone),
        .cmpRise  (cmpRise),
        .pi1      (pi1),
        .pi2      (pi2),
        .pii1     (pii1),
        .pii2     (pii2),
        .pa       (pa),
        .pb       (pb),
        .pc       (pc),
        .pd       (pd),
        .srcN     (srcN),
        .snk      (snk),
        .cmpP1    (cmpP1),
        .cmpP2    (cmpP2)
    );

    conversionCounter conversionCounter_inst (
        .clk      (clk),
        .reset    (reset),
        .phase    (phase),
        .cmpRise  (cmpRise),
        .tmpCount (tmpCount),
        .valid    (valid)
    );

endmodule

`default_nettype wire

// ==== bench/tempSensCtrl_chk.sv ====
`default_nettype none

module tempSensCtrl_chk (
    input wire clk,
    input wire reset,
    input wire pwrUp,
    input wire preChrg,
    input wire sBgCtrl,
    input wire sPtatCtrl,
    input wire sCap2Cmp,
    input wire pi1,
    input wire pi2,
    input wire pii1,
    input wire pii2,
    input wire pa,
    input wire pb,
    input wire pc,
    input wire pd,
    input wire srcN,
    input wire snk,
    input wire cmpP1,
    input wire cmpP2,
    input wire valid
);

    resetLevels: assert property (@(posedge clk)
        (reset && $past(reset)) |->
            (!valid && !sCap2Cmp && preChrg && pwrUp &&
             !(pi1 || pi2 || pii1 || pii2 || pa || pb || pc || pd || srcN || snk)))
        else $error("Outputs left their reset levels while reset was held");

    // Chopping pair never overlaps
    chopInverse: assert property (@(posedge clk) cmpP2 == !cmpP1)
        else $error("cmpP2 is not the inverse of cmpP1");

    diodeIsolation: assert property (@(posedge clk) disable iff (reset)
        (pi1 || pii1) |-> !(pa || pb || pc || pd))
        else $error("Capacitor switch closed while a diode was selected");

    bgBeforePtat: assert property (@(posedge clk) disable iff (reset)
        $rose(sPtatCtrl) |-> $past(sBgCtrl))
        else $error("PTAT control rose without a preceding bandgap phase");

    // Result and power-down follow the window close
    validAfterWindow: assert property (@(posedge clk) disable iff (reset)
        $fell(sCap2Cmp) |-> (valid && !pwrUp))
        else $error("No valid pulse or sleep after the conversion window closed");

endmodule

`default_nettype wire

// ==== bench/tempSensCtrlTb.sv ====
`default_nettype none

`include "tempSens_consts.svh"

module tempSensCtrlTb;

    localparam int MAX_COUNT = (1 << `COUNT_WIDTH) - 1;
    // Pulses that start a cycle into the window and fall before it closes
    localparam int PULSE_FIT = (`TEMPSENS_CYCLES - 5) / 6 + 1;
    // Upper bound on one full measurement loop in clk cycles
    localparam int MEAS_CYCLES = `PRECHARGE_CYCLES +
        (`BANDGAP_CHOPS * 7 + `PTAT_CHOPS * 2) * (`BIGDIODE_MAX + `DIODE_CYCLES + 1) +
        `TEMPSENS_CYCLES + `SLEEP_CYCLES;

    logic clk;
    logic reset;
    logic cmp;
    logic pwrUp, preChrg, sBgCtrl, sPtatCtrl, sBg2Cmp, sRdisconN;
    logic sCap2Cmp, sRef2Cmp, sCapRst, sPtatOut;
    logic pi1, pi2, pii1, pii2, pa, pb, pc, pd, srcN, snk;
    logic cmpP1, cmpP2, valid;
    logic [`COUNT_WIDTH-1:0] tmpCount;

    int  reqQ[$];
    int  expQ[$];
    int  errors = 0;
    int  checks = 0;
    bit  loaded = 1'b0;
    bit  bgSeen = 1'b0;
    bit  ptatPrev = 1'b0;

    tempSensCtrl tempSensCtrl_inst (.*);

    bind tempSensCtrl tempSensCtrl_chk tempSensCtrl_chk_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input int got, input int exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic readPatterns();
        int    fd;
        int    pulses;
        int    expected;
        string line;
        fd = $fopen("bench/tempSensPatterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the pattern file bench/tempSensPatterns.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    if ($sscanf(line, "%d %d", pulses, expected) == 2) begin
                        reqQ.push_back(pulses);
                        expQ.push_back(expected);
                    end
                end
            end
            $fclose(fd);
            if (reqQ.size() == 0) begin
                errors++;
                $display("The pattern file holds no measurements");
            end
        end
    endtask

    // One conversion window with its result and sleep
    task automatic runMeasurement(input int idx);
        int   driven;
        int   k;
        int   highCycles;
        int   sleepCycles;
        logic startP1;
        driven = (reqQ[idx] < PULSE_FIT) ? reqQ[idx] : PULSE_FIT;
        check(expQ[idx], (driven < MAX_COUNT) ? driven : MAX_COUNT, "pattern file count");
        @(negedge clk);
        while (!sCap2Cmp) begin
            @(negedge clk);
        end
        startP1 = cmpP1;
        highCycles = 1;
        k = 0;
        while (sCap2Cmp) begin
            @(posedge clk);
            cmp <= (k / 6 < driven) && (k % 6 < 3);
            k++;
            @(negedge clk);
            if (sCap2Cmp) begin
                highCycles++;
            end
        end
        check(highCycles, `TEMPSENS_CYCLES, "sCap2Cmp high cycles");
        check(valid, 1, "valid after window");
        check(tmpCount, expQ[idx], $sformatf("tmpCount for %0d pulses", reqQ[idx]));
        check(cmpP1, startP1 ^ driven[0], "cmpP1 at window end");
        sleepCycles = 0;
        while (!pwrUp) begin
            sleepCycles++;
            @(negedge clk);
            if (sleepCycles == 1) begin
                check(valid, 0, "valid one cycle later");
            end
        end
        check(sleepCycles, `SLEEP_CYCLES, "pwrUp low cycles");
    endtask

    // Running checks on chopping, diode isolation, routing and phase order
    always @(negedge clk) begin
        if (!reset) begin
            check(cmpP2, !cmpP1, "cmpP2 inverse");
            if (pi1 || pii1) begin
                check({pa, pb, pc, pd}, 0, "capacitor switches with diode selected");
            end
            if (sBgCtrl) begin
                check(sRdisconN, 1, "resistor closed with bandgap control");
            end
            check(sRef2Cmp, sCap2Cmp, "reference routed in window");
            check(sPtatOut, sCap2Cmp, "PTAT output routed in window");
            check(sCapRst, !sCap2Cmp, "capacitor reset outside window");
            check(sBg2Cmp, (sBgCtrl && !preChrg) || (sPtatCtrl && !sCap2Cmp),
                  "bandgap routed in chopped phases");
            if (!pwrUp) begin
                bgSeen = 1'b0;
            end
            if (sBgCtrl) begin
                bgSeen = 1'b1;
            end
            if (sPtatCtrl && !ptatPrev) begin
                check(bgSeen, 1, "bandgap before PTAT");
            end
            ptatPrev = sPtatCtrl;
        end
    end

    initial begin
        int highCycles;
        reset = 1'b1;
        cmp   = 1'b0;
        readPatterns();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check({pi1, pi2, pii1, pii2, pa, pb, pc, pd, srcN, snk}, 0, "switches in reset");
        check({valid, sCap2Cmp, sRef2Cmp, preChrg, pwrUp}, 5'b00011, "levels in reset");
        @(posedge clk);
        reset <= 1'b0;
        highCycles = 0;
        @(negedge clk);
        while (preChrg) begin
            highCycles++;
            @(negedge clk);
        end
        check(highCycles, `PRECHARGE_CYCLES, "preChrg high cycles");
        for (int i = 0; i < reqQ.size(); i++) begin
            runMeasurement(i);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = longint'(reqQ.size() + 1) * MEAS_CYCLES * 4 * 2;
        #(limit);
        $display("The run timed out after %0d time units", limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tempSensPatterns.txt ====
// pulses: cmp pulses requested in the window, expected: tmpCount after it
// the window holds 33 pulses at most, a longer request is cut to that
0 0
1 1
2 2
5 5
12 12
20 20
32 32
33 33
300 33

// ==== project.f ====
+incdir+hdl
hdl/tempSensPkg.sv
hdl/phaseSequencer.sv
hdl/switchSequencer.sv
hdl/conversionCounter.sv
hdl/tempSensCtrl.sv
bench/tempSensCtrl_chk.sv
bench/tempSensCtrlTb.sv
